// ==== design/vectrex_pkg.sv ====
// core-side types
// settings register select enum and settings bank struct
// controller input and console pad structs

package vectrex_pkg;

  //////////////////////////////////////////////////
  // settings bank

  // register select, decoded from addr[31:24]
  typedef enum logic [7:0] {
    sel_persistence    = 8'h80,  // phosphor persistence level
    sel_overburn       = 8'h90,
    sel_show_bg        = 8'hA0,  // overlay on/off
    sel_phosphor_decay = 8'hC0,  // custom decay curve
    sel_none           = 8'hFF   // anything else, no register
  } setting_sel_e;

  typedef struct packed {
    logic [4:0] persistence;     // from wr_data[4:0]
    logic       overburn;        // from wr_data[0]
    logic       show_bg;
    logic       phosphor_decay;
  } core_settings_t;

  //////////////////////////////////////////////////
  // controllers

  // one pocket controller as seen by the core
  typedef struct packed {
    logic [31:0] key;            // button bitmap, dpad in [3:0]
    logic [31:0] joy;            // lstick x [7:0], lstick y [15:8]
  } cont_in_t;

  // what the console sees per controller
  typedef struct packed {
    logic       up;
    logic       down;
    logic       left;
    logic       right;
    logic [7:0] pot_x;           // 0x80 is centre
    logic [7:0] pot_y;
  } console_pad_t;

endpackage

// ==== design/video_pkg.sv ====
// pixel-side types
// colour channel, rgb pixel, 4-bit rgba overlay pixel
// beam timing from the console

package video_pkg;

  //////////////////////////////////////////////////
  // colour

  typedef logic [7:0] chan_t;    // one 8-bit colour channel

  typedef struct packed {
    chan_t r;                    // [23:16] on the scaler bus
    chan_t g;
    chan_t b;
  } rgb_t;

  // overlay pixel, nibble packed as a,b,g,r
  // matches the rgba word order of the overlay image
  typedef struct packed {
    logic [3:0] a;               // alpha, 0 = full black
    logic [3:0] b;
    logic [3:0] g;
    logic [3:0] r;
  } overlay_px_t;

  //////////////////////////////////////////////////
  // beam

  // beam state per clk_24 cycle
  typedef struct packed {
    logic hblank;                // high outside the active line
    logic vblank;                // high outside the active frame
    rgb_t color;                 // beam intensity, zero when no beam
  } beam_t;

endpackage

// ==== design/core_settings_regs.sv ====
// core settings bank
// write strobe decode of addr top byte into four registers

`timescale 1ns/1ps

module core_settings_regs (
  input  logic                        clk_24,
  input  logic                        arst_n,
  input  logic                        wr,        // single-cycle write strobe
  input  logic [31:0]                 addr,      // select in [31:24]
  input  logic [31:0]                 wr_data,
  output vectrex_pkg::core_settings_t settings
);
  import vectrex_pkg::*;

  setting_sel_e sel;

  //////////////////////////////////////////////////
  // address decode

  always_comb begin
    case (addr[31:24])
      sel_persistence:    sel = sel_persistence;
      sel_overburn:       sel = sel_overburn;
      sel_show_bg:        sel = sel_show_bg;
      sel_phosphor_decay: sel = sel_phosphor_decay;
      default:            sel = sel_none;       // unmapped select
    endcase
  end

  //////////////////////////////////////////////////
  // registers

  always_ff @(posedge clk_24 or negedge arst_n) begin
    if (!arst_n) begin
      settings <= '0;
    end else if (wr) begin
      // only the selected field moves
      case (sel)
        sel_persistence:    settings.persistence    <= wr_data[4:0];
        sel_overburn:       settings.overburn       <= wr_data[0];
        sel_show_bg:        settings.show_bg        <= wr_data[0];
        sel_phosphor_decay: settings.phosphor_decay <= wr_data[0];
        default:            ;                   // sel_none, hold all
      endcase
    end
  end

endmodule

// ==== design/joystick_mapper.sv ====
// controller to console mapping
// face buttons to up/down/left/right, stick or dpad to pot values
// both controllers registered, one cycle latency

`timescale 1ns/1ps

module joystick_mapper (
  input  logic                      clk_24,
  input  logic                      arst_n,
  input  vectrex_pkg::cont_in_t     cont1,
  input  vectrex_pkg::cont_in_t     cont2,
  output vectrex_pkg::console_pad_t pad1,
  output vectrex_pkg::console_pad_t pad2
);
  import vectrex_pkg::*;

  // one controller, same rules for both ports
  function automatic console_pad_t map_pad(input cont_in_t c);
    logic [7:0]   stick_x;
    logic [7:0]   stick_y;
    logic [7:0]   dpad_x;
    logic [7:0]   dpad_y;
    logic         analog;
    console_pad_t p;
    // unsigned stick to console offset, y axis flipped
    stick_x = c.joy[7:0] + 8'd128;
    stick_y = ~(c.joy[15:8] + 8'd128);
    analog  = |c.joy[15:0];               // any stick deflection
    // dpad gives 0x00, 0x7f or 0x80
    dpad_x  = {c.key[2], {7{c.key[3]}}};  // left, right
    dpad_y  = {c.key[1], {7{c.key[0]}}};  // down, up
    p.up    = c.key[6];                   // face x
    p.down  = c.key[5];                   // face b
    p.left  = c.key[7];                   // face y
    p.right = c.key[4];                   // face a
    // dpad wins when pressed on that axis
    p.pot_x = (!analog || (c.key[2] || c.key[3])) ? dpad_x : stick_x;
    p.pot_y = (!analog || (c.key[0] || c.key[1])) ? dpad_y : stick_y;
    return p;
  endfunction

  //////////////////////////////////////////////////
  // output registers

  always_ff @(posedge clk_24 or negedge arst_n) begin
    if (!arst_n) begin
      pad1 <= '0;
      pad2 <= '0;
    end else begin
      pad1 <= map_pad(cont1);
      pad2 <= map_pad(cont2);
    end
  end

endmodule

// ==== design/overlay_blender.sv ====
// beam and overlay blend, purely combinational
// bright beam tints toward white, no beam shows alpha-dimmed overlay

`timescale 1ns/1ps

module overlay_blender #(
  parameter video_pkg::chan_t BRIGHT_THRESHOLD = 8'd108  // beam red above this tints
) (
  input  video_pkg::rgb_t        beam_rgb,
  input  video_pkg::overlay_px_t overlay,
  input  logic                   show_bg,
  output video_pkg::rgb_t        pixel
);
  import video_pkg::*;

  // 4-bit to 8-bit, nibble repeated
  function automatic chan_t expand(input logic [3:0] n);
    return {n, n};
  endfunction

  // c + 3/4 of the headroom to white
  function automatic chan_t tint_white(input chan_t c);
    chan_t headroom;
    headroom = 8'd255 - c;
    return c + (headroom >> 1) + (headroom >> 2);  // never exceeds 255
  endfunction

  // c * a / 16, truncated
  function automatic chan_t alpha_dim(input chan_t c, input logic [3:0] a);
    logic [11:0] prod;
    prod = c * a;
    return prod[11:4];
  endfunction

  overlay_px_t ov;      // overlay after show_bg gate
  rgb_t        bg_exp;  // overlay colour at 8 bits
  rgb_t        base;
  logic        fg;      // beam at this pixel
  logic        bg;      // overlay has colour here
  logic        bright;

  assign ov       = show_bg ? overlay : '0;  // overlay off reads as black
  assign bg_exp.r = expand(ov.r);
  assign bg_exp.g = expand(ov.g);
  assign bg_exp.b = expand(ov.b);

  assign fg     = |beam_rgb;
  assign bg     = |{ov.r, ov.g, ov.b};       // alpha alone is not colour
  assign bright = beam_rgb.r > BRIGHT_THRESHOLD;
  assign base   = bg ? bg_exp : beam_rgb;    // light through the overlay

  always_comb begin
    if (fg) begin
      pixel.r = bright ? tint_white(base.r) : base.r;
      pixel.g = bright ? tint_white(base.g) : base.g;
      pixel.b = bright ? tint_white(base.b) : base.b;
    end else begin
      // unlit overlay, darkened by alpha
      pixel.r = alpha_dim(bg_exp.r, ov.a);
      pixel.g = alpha_dim(bg_exp.g, ov.a);
      pixel.b = alpha_dim(bg_exp.b, ov.a);
    end
  end

endmodule

// ==== design/video_output_stage.sv ====
// video output stage
// blender plus output registers for de, rgb and sync pulses
// syncs are one-cycle pulses on blanking rising edges

`timescale 1ns/1ps

module video_output_stage #(
  parameter video_pkg::chan_t BRIGHT_THRESHOLD = 8'd108
) (
  input  logic                   clk_24,
  input  logic                   arst_n,
  input  video_pkg::beam_t       beam,
  input  video_pkg::overlay_px_t overlay,
  input  logic                   show_bg,
  output video_pkg::rgb_t        video_rgb,
  output logic                   video_de,
  output logic                   video_hs,
  output logic                   video_vs
);
  import video_pkg::*;

  rgb_t pixel;     // blended colour, this cycle
  logic blank;
  logic hblank_q;  // previous blanking samples
  logic vblank_q;

  overlay_blender #(
    .BRIGHT_THRESHOLD (BRIGHT_THRESHOLD)
  ) blender_i (
    .beam_rgb (beam.color),
    .overlay  (overlay),
    .show_bg  (show_bg),
    .pixel    (pixel)
  );

  assign blank = beam.hblank | beam.vblank;

  always_ff @(posedge clk_24 or negedge arst_n) begin
    if (!arst_n) begin
      video_de  <= 1'b0;
      video_rgb <= '0;
      video_hs  <= 1'b0;
      video_vs  <= 1'b0;
      hblank_q  <= 1'b0;
      vblank_q  <= 1'b0;
    end else begin
      video_de  <= !blank;
      video_rgb <= blank ? '0 : pixel;         // black in blanking
      video_hs  <= beam.hblank & ~hblank_q;    // rising edge only
      video_vs  <= beam.vblank & ~vblank_q;
      hblank_q  <= beam.hblank;
      vblank_q  <= beam.vblank;
    end
  end

endmodule

// ==== design/vectrex_io_top.sv ====
// top level of the clk_24 glue
// settings bank, joystick mapper and video output stage

`timescale 1ns/1ps

module vectrex_io_top #(
  parameter video_pkg::chan_t BRIGHT_THRESHOLD = 8'd108  // red level for white tint
) (
  input  logic                        clk_24,
  input  logic                        arst_n,
  // settings write strobe
  input  logic                        wr,
  input  logic [31:0]                 addr,
  input  logic [31:0]                 wr_data,
  // controllers
  input  vectrex_pkg::cont_in_t       cont1,
  input  vectrex_pkg::cont_in_t       cont2,
  // console beam and overlay pixel
  input  video_pkg::beam_t            beam,
  input  video_pkg::overlay_px_t      overlay,
  // outputs
  output vectrex_pkg::core_settings_t settings,
  output vectrex_pkg::console_pad_t   pad1,
  output vectrex_pkg::console_pad_t   pad2,
  output video_pkg::rgb_t             video_rgb,
  output logic                        video_de,
  output logic                        video_hs,
  output logic                        video_vs
);

  core_settings_regs settings_i (
    .clk_24   (clk_24),
    .arst_n   (arst_n),
    .wr       (wr),
    .addr     (addr),
    .wr_data  (wr_data),
    .settings (settings)
  );

  joystick_mapper joy_i (
    .clk_24 (clk_24),
    .arst_n (arst_n),
    .cont1  (cont1),
    .cont2  (cont2),
    .pad1   (pad1),
    .pad2   (pad2)
  );

  // show_bg taps straight off the settings bank
  video_output_stage #(
    .BRIGHT_THRESHOLD (BRIGHT_THRESHOLD)
  ) video_i (
    .clk_24    (clk_24),
    .arst_n    (arst_n),
    .beam      (beam),
    .overlay   (overlay),
    .show_bg   (settings.show_bg),
    .video_rgb (video_rgb),
    .video_de  (video_de),
    .video_hs  (video_hs),
    .video_vs  (video_vs)
  );

endmodule

// ==== tests/vectrex_io_sva.sv ====
// bound checks on the video output stage
// sync pulses one cycle wide and following blanking rises, de low after blanking

`timescale 1ns/1ps

module vectrex_io_sva (
  input logic             clk_24,
  input logic             arst_n,
  input video_pkg::beam_t beam,
  input logic             video_de,
  input logic             video_hs,
  input logic             video_vs
);

  logic blank;

  assign blank = beam.hblank | beam.vblank;

  hs_single: assert property (@(posedge clk_24) disable iff (!arst_n)
    video_hs |=> !video_hs)
    else $error("hs pulse wider than one cycle");

  vs_single: assert property (@(posedge clk_24) disable iff (!arst_n)
    video_vs |=> !video_vs)
    else $error("vs pulse wider than one cycle");

  // pulse one edge after the rise is sampled
  hs_follows: assert property (@(posedge clk_24) disable iff (!arst_n)
    $rose(beam.hblank) |=> video_hs)
    else $error("no hs pulse after hblank rise");

  vs_follows: assert property (@(posedge clk_24) disable iff (!arst_n)
    $rose(beam.vblank) |=> video_vs)
    else $error("no vs pulse after vblank rise");

  de_blank: assert property (@(posedge clk_24) disable iff (!arst_n)
    blank |=> !video_de)
    else $error("de high after blanking was sampled");

endmodule

bind video_output_stage vectrex_io_sva sva_i (
  .clk_24   (clk_24),
  .arst_n   (arst_n),
  .beam     (beam),
  .video_de (video_de),
  .video_hs (video_hs),
  .video_vs (video_vs)
);

// ==== tests/tb_vectrex_io.sv ====
// testbench for the clk_24 glue
// vectors from the tests table, each checked against the table and an own model
// one count line at the end, then the verdict

`timescale 1ns/1ps

module tb_vectrex_io;
  import vectrex_pkg::*;
  import video_pkg::*;

  localparam int         MAX_VECTORS      = 64;     // bound on the vector walk
  localparam logic [7:0] BRIGHT_THRESHOLD = 8'd108;
  localparam logic [7:0] OP_WRITE         = 8'h01;  // settings write
  localparam logic [7:0] OP_IDLE          = 8'h02;  // addr/data driven, no strobe
  localparam logic [7:0] OP_PAD           = 8'h03;
  localparam logic [7:0] OP_VIDEO         = 8'h04;
  localparam logic [7:0] OP_END           = 8'hFF;

  logic           clk_24;
  logic           arst_n;
  logic           wr;
  logic [31:0]    addr;
  logic [31:0]    wr_data;
  cont_in_t       cont1;
  cont_in_t       cont2;
  beam_t          beam;
  overlay_px_t    overlay;
  core_settings_t settings;
  console_pad_t   pad1;
  console_pad_t   pad2;
  rgb_t           video_rgb;
  logic           video_de;
  logic           video_hs;
  logic           video_vs;

  logic [103:0]   vectors [MAX_VECTORS];  // op, a, b, expected
  int             errors;
  int             timeouts;
  integer         seed;
  logic [7:0]     model_settings;         // reference copy of the bank
  logic           prev_hblank;            // last blanking levels driven
  logic           prev_vblank;
  logic [7:0]     pend_op;                // vector driven, not yet checked
  logic [31:0]    pend_exp;
  logic [31:0]    pend_exp2;              // pad2, from its own stimulus

  initial clk_24 = 1'b0;
  always #10 clk_24 = ~clk_24;            // 20 ns period

  vectrex_io_top #(
    .BRIGHT_THRESHOLD (BRIGHT_THRESHOLD)
  ) dut_i (
    .clk_24    (clk_24),
    .arst_n    (arst_n),
    .wr        (wr),
    .addr      (addr),
    .wr_data   (wr_data),
    .cont1     (cont1),
    .cont2     (cont2),
    .beam      (beam),
    .overlay   (overlay),
    .settings  (settings),
    .pad1      (pad1),
    .pad2      (pad2),
    .video_rgb (video_rgb),
    .video_de  (video_de),
    .video_hs  (video_hs),
    .video_vs  (video_vs)
  );

  //////////////////////////////////////////////////
  // reference model

  // bank layout: persistence[7:3], overburn, show_bg, decay
  function automatic logic [7:0] next_settings(input logic [7:0] cur,
                                               input logic [31:0] a,
                                               input logic [31:0] d);
    logic [7:0] s;
    s = cur;
    if (a[31:24] == 8'h80) s[7:3] = d[4:0];
    else if (a[31:24] == 8'h90) s[2] = d[0];
    else if (a[31:24] == 8'hA0) s[1] = d[0];
    else if (a[31:24] == 8'hC0) s[0] = d[0];
    return s;  // other selects leave the bank alone
  endfunction

  // {up, down, left, right, pot_x, pot_y}
  function automatic logic [19:0] expect_pad(input logic [7:0] key, input logic [31:0] joy);
    int         sx;
    int         sy;
    logic [7:0] dx;
    logic [7:0] dy;
    logic [7:0] px;
    logic [7:0] py;
    sx = (int'(joy[7:0]) + 128) % 256;
    sy = 255 - (int'(joy[15:8]) + 128) % 256;       // y flipped
    dx = (key[2] ? 8'h80 : 8'h00) | (key[3] ? 8'h7F : 8'h00);
    dy = (key[1] ? 8'h80 : 8'h00) | (key[0] ? 8'h7F : 8'h00);
    if (joy[15:0] == 16'h0 || key[2] || key[3]) px = dx;
    else px = 8'(sx);
    if (joy[15:0] == 16'h0 || key[0] || key[1]) py = dy;
    else py = 8'(sy);
    return {key[6], key[5], key[7], key[4], px, py};
  endfunction

  // channel order r, g, b; overlay nibbles r at [3:0], alpha at [15:12]
  function automatic logic [23:0] expect_blend(input logic [23:0] beam_c,
                                               input logic [15:0] ov,
                                               input logic show);
    int bg_ch [3];
    int bm_ch [3];
    int out_ch [3];
    int alpha;
    int base;
    bit fg_on;
    bit bg_on;
    alpha = show ? int'(ov[15:12]) : 0;
    for (int k = 0; k < 3; k++) begin
      bm_ch[k] = int'(beam_c[23 - 8*k -: 8]);
      bg_ch[k] = show ? int'(ov[4*k +: 4]) * 17 : 0;  // nibble times 17 = repeat
    end
    fg_on = (beam_c != 24'h0);
    bg_on = (bg_ch[0] + bg_ch[1] + bg_ch[2]) != 0;
    for (int k = 0; k < 3; k++) begin
      base = bg_on ? bg_ch[k] : bm_ch[k];
      if (!fg_on) out_ch[k] = bg_ch[k] * alpha / 16;
      else if (bm_ch[0] > int'(BRIGHT_THRESHOLD))
        out_ch[k] = base + (255 - base) / 2 + (255 - base) / 4;
      else out_ch[k] = base;
    end
    return {8'(out_ch[0]), 8'(out_ch[1]), 8'(out_ch[2])};
  endfunction

  //////////////////////////////////////////////////
  // drive and check

  task automatic compare_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
    assert (got === exp) else begin
      errors++;
      $display("MISMATCH %0t: %s got %h, expected %h", $time, what, got, exp);
    end
  endtask

  // drive one vector on this edge, remember its expected outputs
  task automatic apply_vector(input logic [103:0] v);
    logic [7:0]  op;
    logic [31:0] fa;
    logic [31:0] fb;
    logic [31:0] fx;
    logic [31:0] model;
    logic [31:0] exp2;
    logic [31:0] rnd1;
    logic [31:0] rnd2;
    logic [7:0]  key2;
    logic [31:0] joy2;
    logic        blank;
    logic        hs;
    logic        vs;
    op    = v[103:96];
    fa    = v[95:64];
    fb    = v[63:32];
    fx    = v[31:0];
    model = 32'h0;
    exp2  = 32'h0;
    wr   <= 1'b0;
    case (op)
      OP_WRITE, OP_IDLE: begin
        wr      <= (op == OP_WRITE);
        addr    <= fa;
        wr_data <= fb;
        if (op == OP_WRITE) model_settings = next_settings(model_settings, fa, fb);
        model = {24'h0, model_settings};
      end
      OP_PAD: begin
        rnd1 = $random(seed);  // noise in the unused key bits
        rnd2 = $random(seed);
        key2 = {fa[3:0], fa[7:4]};              // nibbles swapped on port 2
        joy2 = {fb[31:16], fb[7:0], fb[15:8]};  // stick axes swapped
        cont1.key <= {rnd1[31:8], fa[7:0]};
        cont1.joy <= fb;
        cont2.key <= {rnd2[31:8], key2};
        cont2.joy <= joy2;
        model = {12'h0, expect_pad(fa[7:0], fb)};
        exp2  = {12'h0, expect_pad(key2, joy2)};
      end
      OP_VIDEO: begin
        beam    <= fa[25:0];
        overlay <= fb[15:0];
        blank = fa[25] | fa[24];
        hs    = fa[25] & ~prev_hblank;
        vs    = fa[24] & ~prev_vblank;
        prev_hblank = fa[25];
        prev_vblank = fa[24];
        model = {5'h0, hs, vs, ~blank,
                 blank ? 24'h0 : expect_blend(fa[23:0], fb[15:0], model_settings[1])};
      end
      OP_END: ;
      default: begin
        errors++;
        $display("ERROR: unknown operation code %h in the vector table", op);
      end
    endcase
    compare_value("table vs model", model, fx);  // catches a bad table line
    pend_op   = op;
    pend_exp  = fx;
    pend_exp2 = exp2;
  endtask

  task automatic check_outputs(input logic [7:0] op, input logic [31:0] exp,
                               input logic [31:0] exp2);
    case (op)
      OP_WRITE, OP_IDLE: compare_value("settings", {24'h0, settings}, exp);
      OP_PAD: begin
        compare_value("pad1", {12'h0, pad1}, exp);
        compare_value("pad2", {12'h0, pad2}, exp2);
      end
      OP_VIDEO: compare_value("video", {5'h0, video_hs, video_vs, video_de, video_rgb}, exp);
      default: ;
    endcase
  endtask

  //////////////////////////////////////////////////
  // main sequence

  initial begin
    int          i;
    bit          done;
    logic [7:0]  chk_op;
    logic [31:0] chk_exp;
    logic [31:0] chk_exp2;
    errors         = 0;
    timeouts       = 0;
    seed           = 32'ha882;
    model_settings = 8'h0;
    prev_hblank    = 1'b0;
    prev_vblank    = 1'b0;
    pend_op        = OP_END;
    pend_exp       = 32'h0;
    pend_exp2      = 32'h0;
    arst_n         = 1'b0;
    wr             = 1'b0;
    addr           = 32'h0;
    wr_data        = 32'h0;
    cont1          = '0;
    cont2          = '0;
    beam           = '0;
    overlay        = '0;
    $readmemh("tests/vectrex_io_tests.mem", vectors);
    repeat (3) @(posedge clk_24);
    arst_n <= 1'b1;
    done = 1'b0;
    i    = 0;
    // one vector per cycle, each checked one edge after it was driven
    while (!done && i < MAX_VECTORS) begin
      @(posedge clk_24);
      chk_op   = pend_op;
      chk_exp  = pend_exp;
      chk_exp2 = pend_exp2;
      apply_vector(vectors[i]);
      done = (vectors[i][103:96] == OP_END);
      i++;
      @(negedge clk_24);
      check_outputs(chk_op, chk_exp, chk_exp2);
    end
    if (!done) begin
      timeouts++;
      $display("ERROR: no end marker within %0d vectors, run stopped", MAX_VECTORS);
    end
    $display("vectors %0d, errors %0d, timeouts %0d", i, errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

// ==== tests/vectrex_io_tests.mem ====
// columns: op (2 hex) then a, b, expected (8 hex each), no separators
// 01 write addr,data 02 no strobe 03 key,joy 04 {hb,vb,rgb},overlay ff end
018000000000000015000000A8
019000000000000001000000AC
01A000000000000001000000AE
01C000000000000003000000AF
01B00000000000001F000000AF
028000000000000000000000AF
019000000000000002000000AB
0180000000000000E30000001B
03000000500000000000090000
03000000A5000000000006807F
0300000000000030100000904F
0300000004000030100000804F
03000000010000F0C50000457F
03000000F8FFFF0000000F7F00
030000000000008000000080FF
04004020100000000001402010
04008040000000000001DECEBE
04001010100000F28401448822
0400FF000000008C3101C3CCF1
040000000000008C3101081966
04000000000000F284013F7F1F
04002030400000F00001203040
04022030400000F00004000000
04022030400000F00000000000
04002030400000F00001203040
04010000000000000002000000
04030000000000000004000000
04004020100000000001402010
01A00000000000000000000019
04001010100000F28401101010
04000000000000F28401000000
FF000000000000000000000000

// ==== files.f ====
design/vectrex_pkg.sv
design/video_pkg.sv
design/core_settings_regs.sv
design/joystick_mapper.sv
design/overlay_blender.sv
design/video_output_stage.sv
design/vectrex_io_top.sv
tests/vectrex_io_sva.sv
tests/tb_vectrex_io.sv

// ==== Makefile ====
# Verilator flow for the clk_24 glue

VERILATOR ?= verilator
TB_TOP    ?= tb_vectrex_io
RTL_TOP   ?= vectrex_io_top
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
PASS_MSG  ?= >>> PASS
VFLAGS    ?= --timing --assert --timescale 1ns/1ps
SIM_FLAGS ?= -Wno-fatal

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) $(SIM_FLAGS) --top-module $(TB_TOP) \
		-f $(FILELIST) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TB_TOP))"; echo "$$out"; \
		echo "$$out" | grep -qF -- '$(PASS_MSG)'

clean:
	rm -rf $(BUILD_DIR)
